//--- Bender.yml
package:
  name: rv_front_end

sources:
  - files:
      - hw/rvFrontEndPkg.sv
      - hw/frontEndIfs.sv
      - hw/fetchUnit.sv
      - hw/instrQueue.sv
      - hw/instrDecoder.sv
      - hw/frontEndTop.sv
  - target: simulation
    files:
      - dv/tbClockGen.sv
      - dv/frontEndTb.sv

//--- dv/decodeInput.txt
// Header: row count, row index that the redirect jumps to
10 05
// Rows: instr class rd rs1 rs2 funct3 imm, row i sits at address 4*i
00500093 7 01 00 05 0 00000005
FFF08113 7 02 01 1F 0 FFFFFFFF
123452B7 0 05 08 03 5 12345000
FFFFF197 1 03 1F 1F 7 FFFFF000
008000EF 2 01 00 08 0 00000008
FFDFF06F 2 00 1F 1D 7 FFFFFFFC
00008067 3 00 01 00 0 00000000
FE208CE3 4 19 01 02 0 FFFFFFF8
00C12303 5 06 02 0C 2 0000000C
FE612E23 6 1C 02 06 2 FFFFFFFC
006283B3 8 07 05 06 0 00000000
40138433 8 08 07 01 0 00000000
0FF0000F 9 00 00 1F 0 00000000
00000073 A 00 00 00 0 00000000
FFFFFFFF B 1F 1F 1F 7 00000000
7FF47493 7 09 08 1F 7 000007FF

//--- dv/frontEndTb.sv
`timescale 1ns/1ps

module frontEndTb;
	import rvFrontEndPkg::*;

	localparam int maxDelay  = 3;
	localparam int maxStall  = 7;
	localparam int rowWords  = 7;
	localparam int tReset    = 0;
	localparam int tSeq      = 1;
	localparam int tDecode   = 2;
	localparam int tBackPres = 3;
	localparam int tRedirect = 4;

	logic clk, arstN, redirect, arvalid, arready, rvalid, rready, stall, decValid;
	logic [xlen-1:0] redirectPc, araddr, rdata, decPc, decImm;
	logic [regIdxW-1:0] decRd, decRs1, decRs2;
	logic [2:0] decFunct3;
	instrClass_t decClass;

	logic [31:0] dataWords [0:255];
	int nRows, redirRow, arCnt, rCnt, stallCnt, beats, beatsAfter, holdCycles;
	logic [31:0] memRng, stallRng, pendAddr, expAr, expPc;
	logic [31:0] heldPc, heldImm, heldFields;
	logic rPend, heldLast, redirectSeen, firstAfter;
	string testNames [5];
	int errors [5];
	int checks [5];

	tbClockGen #(.period(40ns), .resetCycles(8)) clkGen (.clk(clk), .arstN(arstN));

	frontEndTop dut (
		.clk(clk), .arstN(arstN), .redirect(redirect), .redirectPc(redirectPc),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rvalid(rvalid), .rready(rready),
		.stall(stall), .decValid(decValid), .decPc(decPc), .decClass(decClass),
		.decRd(decRd), .decRs1(decRs1), .decRs2(decRs2),
		.decFunct3(decFunct3), .decImm(decImm)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] rowField(input int row, input int col);
		return dataWords[2 + row * rowWords + col];
	endfunction

	// Words past the table get an address-derived pattern
	function automatic logic [31:0] memWord(input logic [31:0] addr);
		if (addr[1:0] == 2'b00 && (addr >> 2) < nRows) begin
			return rowField(addr >> 2, 0);
		end
		return {addr[15:0] ^ 16'hc3a5, addr[31:16] ^ 16'h5a3c};
	endfunction

	task automatic compareVal(input int testId, input string what,
			input logic [31:0] expected, input logic [31:0] actual);
		checks[testId]++;
		if (expected !== actual) begin
			$display("Mismatch %s %s expected %h actual %h",
				testNames[testId], what, expected, actual);
			errors[testId]++;
		end
	endtask

	// ========================================
	// AXI read memory model
	// ========================================
	always @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
			rdata   <= '0;
			rPend   = 1'b0;
			arCnt   = 0;
			rCnt    = 0;
		end else begin
			if (rvalid && rready) begin
				rvalid <= 1'b0;
			end else if (rPend && !rvalid) begin
				if (rCnt == 0) begin
					rvalid <= 1'b1;
					rdata  <= memWord(pendAddr);
					rPend  = 1'b0;
				end else begin
					rCnt--;
				end
			end
			if (arvalid && arready) begin
				arready <= 1'b0;
				pendAddr = araddr;
				rPend    = 1'b1;
				memRng   = xorshift(memRng);
				rCnt     = memRng % (maxDelay + 1);
				memRng   = xorshift(memRng);
				arCnt    = memRng % (maxDelay + 1);
			end else if (arvalid) begin
				if (arCnt == 0) begin
					arready <= 1'b1;
				end else begin
					arCnt--;
				end
			end
		end
	end

	// Random stall bursts
	always @(posedge clk) begin
		if (arstN) begin
			if (stallCnt == 0) begin
				stallRng = xorshift(stallRng);
				stall    <= stallRng[0];
				stallCnt = stallRng[3:1];
			end else begin
				stallCnt--;
			end
		end
	end

	// ========================================
	// Output monitor
	// ========================================
	always @(posedge clk) begin
		if (arstN) begin
			if (arvalid && arready && !redirectSeen) begin
				compareVal(tSeq, "araddr", expAr, araddr);
				expAr = expAr + instrStep;
			end
			if (heldLast) begin
				holdCycles++;
				compareVal(tBackPres, "held decValid", 32'd1, {31'd0, decValid});
				compareVal(tBackPres, "held decPc", heldPc, decPc);
				compareVal(tBackPres, "held decImm", heldImm, decImm);
				compareVal(tBackPres, "held fields", heldFields,
					{9'd0, decClass, decRd, decRs1, decRs2, decFunct3});
			end
			heldLast   = decValid && stall && !redirect;
			heldPc     = decPc;
			heldImm    = decImm;
			heldFields = {9'd0, decClass, decRd, decRs1, decRs2, decFunct3};
			if (decValid && !stall) begin
				compareVal(firstAfter ? tRedirect : tBackPres, "decPc order", expPc, decPc);
				firstAfter = 1'b0;
				expPc = expPc + instrStep;
				if (decPc[1:0] == 2'b00 && (decPc >> 2) < nRows) begin
					compareVal(tDecode, "decClass", rowField(decPc >> 2, 1), 32'(decClass));
					compareVal(tDecode, "decRd", rowField(decPc >> 2, 2), 32'(decRd));
					compareVal(tDecode, "decRs1", rowField(decPc >> 2, 3), 32'(decRs1));
					compareVal(tDecode, "decRs2", rowField(decPc >> 2, 4), 32'(decRs2));
					compareVal(tDecode, "decFunct3", rowField(decPc >> 2, 5), 32'(decFunct3));
					compareVal(tDecode, "decImm", rowField(decPc >> 2, 6), decImm);
				end
				beats++;
				if (redirectSeen) begin
					beatsAfter++;
				end
			end
			if (redirect) begin
				expPc        = redirectPc;
				redirectSeen = 1'b1;
				firstAfter   = 1'b1;
			end
		end
	end

	// Watchdog sized from the number of beats the run needs
	initial begin
		longint limitCycles;
		#1;
		limitCycles = (2 * nRows + 8) * (2 * maxDelay + 6 + maxStall) * 2;
		#(limitCycles * 40ns);
		$display("Timeout after %0d cycles without finishing the tests", limitCycles);
		$display("SOME TESTS FAILED");
		$finish;
	end

	// ========================================
	// Main sequence
	// ========================================
	initial begin
		int total;
		int failedTests;
		redirect   = 1'b0;
		redirectPc = '0;
		stall      = 1'b0;
		arready    = 1'b0;
		rvalid     = 1'b0;
		rdata      = '0;
		memRng     = 32'hc2ec;
		stallRng   = ~32'hc2ec;
		stallCnt   = 0;
		beats      = 0;
		beatsAfter = 0;
		holdCycles = 0;
		expAr      = resetPc;
		expPc      = resetPc;
		heldLast   = 1'b0;
		redirectSeen = 1'b0;
		firstAfter = 1'b0;
		testNames  = '{"reset", "sequential fetch", "decode", "back-pressure", "redirect"};
		$readmemh("dv/decodeInput.txt", dataWords);
		nRows    = dataWords[0];
		redirRow = dataWords[1];

		while (arstN !== 1'b1) begin
			@(posedge clk);
			compareVal(tReset, "arvalid in reset", 32'd0, {31'd0, arvalid});
			compareVal(tReset, "decValid in reset", 32'd0, {31'd0, decValid});
		end
		// First cycle with the DUT out of reset
		@(posedge clk);
		compareVal(tReset, "arvalid after reset", 32'd1, {31'd0, arvalid});
		compareVal(tReset, "first araddr", resetPc, araddr);
		compareVal(tReset, "rready after reset", 32'd1, {31'd0, rready});
		$display("Test reset: %0d checks, %0d errors", checks[tReset], errors[tReset]);

		while (beats < nRows) @(negedge clk);
		// Pulse the redirect while a request is pending
		do begin
			@(posedge clk);
		end while (!arvalid);
		redirect   <= 1'b1;
		redirectPc <= redirRow * 4;
		@(posedge clk);
		redirect <= 1'b0;
		@(negedge clk);
		if (checks[tSeq] < nRows) begin
			$display("Sequential fetch saw too few accepted reads before the redirect");
			errors[tSeq]++;
		end
		$display("Test sequential fetch: %0d checks, %0d errors", checks[tSeq], errors[tSeq]);

		while (beatsAfter < nRows - redirRow) @(negedge clk);
		$display("Test decode: %0d checks, %0d errors", checks[tDecode], errors[tDecode]);
		if (holdCycles == 0) begin
			$display("Stall never held a valid decode output");
			errors[tBackPres]++;
		end
		$display("Test back-pressure: %0d checks, %0d errors",
			checks[tBackPres], errors[tBackPres]);
		$display("Test redirect: %0d checks, %0d errors", checks[tRedirect], errors[tRedirect]);

		failedTests = 0;
		for (int i = 0; i < 5; i++) begin
			if (errors[i] != 0) begin
				failedTests++;
			end
		end
		total = 5;
		$display("Tests passed %0d failed %0d", total - failedTests, failedTests);
		if (failedTests == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- dv/tbClockGen.sv
`timescale 1ns/1ps

module tbClockGen #(
	parameter realtime period      = 40ns,
	parameter int      resetCycles = 8
) (
	output logic clk,
	output logic arstN
);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	// Reset covers the first resetCycles rising edges
	initial begin
		arstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		arstN <= 1'b1;
	end

endmodule

//--- hw/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit (
	input  logic                           clk,
	input  logic                           arstN,
	input  logic                           redirect,
	input  logic [rvFrontEndPkg::xlen-1:0] redirectPc,
	// AXI read address
	output logic [rvFrontEndPkg::xlen-1:0] araddr,
	output logic                           arvalid,
	input  logic                           arready,
	// AXI read data
	input  logic [rvFrontEndPkg::xlen-1:0] rdata,
	input  logic                           rvalid,
	output logic                           rready,
	fetchPushIf.source                     push
);
	import rvFrontEndPkg::*;

	logic [xlen-1:0] pcQ;
	logic [xlen-1:0] reqPcQ;
	logic            arvalidQ;
	logic            rWaitQ;
	logic            discardQ;
	logic            rreadyQ;
	logic            inFlight;
	logic            issue;
	logic            arFire;
	logic            beat;

	// ========================================
	// Handshake decode
	// ========================================
	assign arFire   = arvalidQ && arready;
	assign beat     = rWaitQ && rvalid && rreadyQ;
	// From AR issue until the R beat lands
	assign inFlight = arvalidQ || rWaitQ;
	// One read at a time, and only with room left in the queue
	assign issue    = !inFlight && !push.almostFull && !redirect;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pcQ      <= resetPc;
			arvalidQ <= 1'b0;
			rWaitQ   <= 1'b0;
			discardQ <= 1'b0;
			rreadyQ  <= 1'b0;
		end else begin
			rreadyQ <= 1'b1;

			if (issue) begin
				arvalidQ <= 1'b1;
			end else if (arFire) begin
				arvalidQ <= 1'b0;
			end

			if (arFire) begin
				rWaitQ <= 1'b1;
			end else if (beat) begin
				rWaitQ <= 1'b0;
			end

			// Stale response still owed by memory
			if (beat) begin
				discardQ <= 1'b0;
			end else if (redirect && inFlight) begin
				discardQ <= 1'b1;
			end

			if (redirect) begin
				pcQ <= redirectPc;
			end else if (beat && !discardQ) begin
				pcQ <= reqPcQ + instrStep;
			end
		end
	end

	// Address of the request, held stable while arvalid waits
	always_ff @(posedge clk) begin
		if (issue) begin
			reqPcQ <= pcQ;
		end
	end

	assign araddr  = reqPcQ;
	assign arvalid = arvalidQ;
	assign rready  = rreadyQ;

	// Beat goes straight into the queue unless a redirect made it stale
	assign push.push  = beat && !discardQ && !redirect;
	assign push.pc    = reqPcQ;
	assign push.instr = rdata;

endmodule

//--- hw/frontEndIfs.sv
`timescale 1ns/1ps

// Fetch unit into the instruction queue
interface fetchPushIf;
	import rvFrontEndPkg::*;

	logic            push;
	logic [xlen-1:0] pc;
	logic [xlen-1:0] instr;
	logic            almostFull;

	modport source (
		output push,
		output pc,
		output instr,
		input  almostFull
	);

	modport sink (
		input  push,
		input  pc,
		input  instr,
		output almostFull
	);
endinterface

// Queue head toward the decoder
interface decodePopIf;
	import rvFrontEndPkg::*;

	logic            notEmpty;
	logic [xlen-1:0] pc;
	logic [xlen-1:0] instr;
	logic            pop;

	modport source (
		output notEmpty,
		output pc,
		output instr,
		input  pop
	);

	modport sink (
		input  notEmpty,
		input  pc,
		input  instr,
		output pop
	);
endinterface

//--- hw/frontEndTop.sv
`timescale 1ns/1ps

module frontEndTop (
	input  logic                              clk,
	input  logic                              arstN,
	input  logic                              redirect,
	input  logic [rvFrontEndPkg::xlen-1:0]    redirectPc,
	// AXI4 read channels
	output logic [rvFrontEndPkg::xlen-1:0]    araddr,
	output logic                              arvalid,
	input  logic                              arready,
	input  logic [rvFrontEndPkg::xlen-1:0]    rdata,
	input  logic                              rvalid,
	output logic                              rready,
	// Decode side
	input  logic                              stall,
	output logic                              decValid,
	output logic [rvFrontEndPkg::xlen-1:0]    decPc,
	output rvFrontEndPkg::instrClass_t        decClass,
	output logic [rvFrontEndPkg::regIdxW-1:0] decRd,
	output logic [rvFrontEndPkg::regIdxW-1:0] decRs1,
	output logic [rvFrontEndPkg::regIdxW-1:0] decRs2,
	output logic [2:0]                        decFunct3,
	output logic [rvFrontEndPkg::xlen-1:0]    decImm
);

	fetchPushIf fetchPush ();
	decodePopIf decodePop ();

	// ========================================
	// Fetch, queue, decode
	// ========================================
	fetchUnit fetch (
		.clk        (clk),
		.arstN      (arstN),
		.redirect   (redirect),
		.redirectPc (redirectPc),
		.araddr     (araddr),
		.arvalid    (arvalid),
		.arready    (arready),
		.rdata      (rdata),
		.rvalid     (rvalid),
		.rready     (rready),
		.push       (fetchPush.source)
	);

	instrQueue queue (
		.clk      (clk),
		.arstN    (arstN),
		.redirect (redirect),
		.push     (fetchPush.sink),
		.pop      (decodePop.source)
	);

	instrDecoder decoder (
		.clk       (clk),
		.arstN     (arstN),
		.redirect  (redirect),
		.stall     (stall),
		.pop       (decodePop.sink),
		.decValid  (decValid),
		.decPc     (decPc),
		.decClass  (decClass),
		.decRd     (decRd),
		.decRs1    (decRs1),
		.decRs2    (decRs2),
		.decFunct3 (decFunct3),
		.decImm    (decImm)
	);

endmodule

//--- hw/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
	input  logic                              clk,
	input  logic                              arstN,
	input  logic                              redirect,
	input  logic                              stall,
	decodePopIf.sink                          pop,
	output logic                              decValid,
	output logic [rvFrontEndPkg::xlen-1:0]    decPc,
	output rvFrontEndPkg::instrClass_t        decClass,
	output logic [rvFrontEndPkg::regIdxW-1:0] decRd,
	output logic [rvFrontEndPkg::regIdxW-1:0] decRs1,
	output logic [rvFrontEndPkg::regIdxW-1:0] decRs2,
	output logic [2:0]                        decFunct3,
	output logic [rvFrontEndPkg::xlen-1:0]    decImm
);
	import rvFrontEndPkg::*;

	opcode_t         opcode;
	instrClass_t     instrClass;
	immFormat_t      immFmt;
	logic [xlen-1:0] ins;
	logic [xlen-1:0] immValue;
	logic            decValidQ;

	function automatic instrClass_t classOf(input opcode_t op);
		case (op)
			opLui:     classOf = classLui;
			opAuipc:   classOf = classAuipc;
			opJal:     classOf = classJal;
			opJalr:    classOf = classJalr;
			opBranch:  classOf = classBranch;
			opLoad:    classOf = classLoad;
			opStore:   classOf = classStore;
			opOpImm:   classOf = classOpImm;
			opOp:      classOf = classOp;
			opMiscMem: classOf = classMiscMem;
			opSystem:  classOf = classSystem;
			default:   classOf = classIllegal;
		endcase
	endfunction

	// R-type, fence, system and unknown opcodes carry no immediate
	function automatic immFormat_t formatOf(input opcode_t op);
		case (op)
			opLui, opAuipc:          formatOf = immU;
			opJal:                   formatOf = immJ;
			opJalr, opLoad, opOpImm: formatOf = immI;
			opBranch:                formatOf = immB;
			opStore:                 formatOf = immS;
			default:                 formatOf = immNone;
		endcase
	endfunction

	// ========================================
	// Field extraction
	// ========================================
	assign ins = pop.instr;

	always_comb begin
		opcode     = opcode_t'(ins[6:0]);
		instrClass = classOf(opcode);
		immFmt     = formatOf(opcode);
		case (immFmt)
			immI:    immValue = {{(xlen-12){ins[31]}}, ins[31:20]};
			immS:    immValue = {{(xlen-12){ins[31]}}, ins[31:25], ins[11:7]};
			immB:    immValue = {{(xlen-13){ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
			immU:    immValue = {ins[31:12], 12'b0};
			immJ:    immValue = {{(xlen-21){ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
			default: immValue = '0;
		endcase
	end

	// Hold everything while downstream stalls
	assign pop.pop = pop.notEmpty && !stall;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			decValidQ <= 1'b0;
		end else if (redirect) begin
			decValidQ <= 1'b0;
		end else if (!stall) begin
			decValidQ <= pop.notEmpty;
		end
	end

	// IF/ID payload
	always_ff @(posedge clk) begin
		if (pop.pop) begin
			decPc     <= pop.pc;
			decClass  <= instrClass;
			decRd     <= ins[11:7];
			decRs1    <= ins[19:15];
			decRs2    <= ins[24:20];
			decFunct3 <= ins[14:12];
			decImm    <= immValue;
		end
	end

	assign decValid = decValidQ;

endmodule

//--- hw/instrQueue.sv
`timescale 1ns/1ps

module instrQueue (
	input logic        clk,
	input logic        arstN,
	input logic        redirect,
	fetchPushIf.sink   push,
	decodePopIf.source pop
);
	import rvFrontEndPkg::*;

	logic [xlen-1:0]      pcMem [queueDepth];
	logic [xlen-1:0]      instrMem [queueDepth];
	logic [queuePtrW-1:0] wrPtrQ;
	logic [queuePtrW-1:0] rdPtrQ;
	logic [queueCntW-1:0] countQ;
	logic                 doPush;
	logic                 doPop;

	assign doPush = push.push && (countQ != queueCntW'(queueDepth));
	assign doPop  = pop.pop && (countQ != '0);

	// ========================================
	// Storage
	// ========================================
	always_ff @(posedge clk) begin
		if (doPush) begin
			pcMem[wrPtrQ]    <= push.pc;
			instrMem[wrPtrQ] <= push.instr;
		end
	end

	// Pointers and fill level that a redirect empties
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wrPtrQ <= '0;
			rdPtrQ <= '0;
			countQ <= '0;
		end else if (redirect) begin
			wrPtrQ <= '0;
			rdPtrQ <= '0;
			countQ <= '0;
		end else begin
			if (doPush) begin
				wrPtrQ <= wrPtrQ + 1'b1;
			end
			if (doPop) begin
				rdPtrQ <= rdPtrQ + 1'b1;
			end
			case ({doPush, doPop})
				2'b10:   countQ <= countQ + 1'b1;
				2'b01:   countQ <= countQ - 1'b1;
				default: countQ <= countQ;
			endcase
		end
	end

	// Fewer than two slots free
	assign push.almostFull = (countQ >= queueCntW'(queueDepth - 1));

	assign pop.notEmpty = (countQ != '0);
	assign pop.pc       = pcMem[rdPtrQ];
	assign pop.instr    = instrMem[rdPtrQ];

endmodule

//--- hw/rvFrontEndPkg.sv
package rvFrontEndPkg;

	// ========================================
	// Widths and sizes
	// ========================================
	localparam int xlen    = 32;
	localparam int regIdxW = 5;

	// First fetch address out of reset
	localparam logic [xlen-1:0] resetPc   = '0;
	localparam logic [xlen-1:0] instrStep = xlen'(4);

	// Queue depth must stay a power of two so the pointers wrap on their own
	localparam int queueDepth = 4;
	localparam int queuePtrW  = $clog2(queueDepth);
	localparam int queueCntW  = queuePtrW + 1;

	// ========================================
	// RV32I major opcodes
	// ========================================
	typedef enum logic [6:0] {
		opLui     = 7'b0110111,
		opAuipc   = 7'b0010111,
		opJal     = 7'b1101111,
		opJalr    = 7'b1100111,
		opBranch  = 7'b1100011,
		opLoad    = 7'b0000011,
		opStore   = 7'b0100011,
		opOpImm   = 7'b0010011,
		opOp      = 7'b0110011,
		opMiscMem = 7'b0001111,
		opSystem  = 7'b1110011
	} opcode_t;

	// Class reported by the decode stage
	typedef enum logic [3:0] {
		classLui     = 4'd0,
		classAuipc   = 4'd1,
		classJal     = 4'd2,
		classJalr    = 4'd3,
		classBranch  = 4'd4,
		classLoad    = 4'd5,
		classStore   = 4'd6,
		classOpImm   = 4'd7,
		classOp      = 4'd8,
		classMiscMem = 4'd9,
		classSystem  = 4'd10,
		classIllegal = 4'd11
	} instrClass_t;

	// Immediate layouts
	typedef enum logic [2:0] {
		immNone,
		immI,
		immS,
		immB,
		immU,
		immJ
	} immFormat_t;

endpackage

//--- sim.f
hw/rvFrontEndPkg.sv
hw/frontEndIfs.sv
hw/fetchUnit.sv
hw/instrQueue.sv
hw/instrDecoder.sv
hw/frontEndTop.sv
dv/tbClockGen.sv
dv/frontEndTb.sv
